/* run_sim.sh */
#!/bin/sh
# build and run the TLX response converter testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f src.f --top-module tb_tlx_rsp_converter -o sim_tlx
out=$(./obj_dir/sim_tlx)
echo "$out"
if echo "$out" | grep -q "^SIMULATION PASSED$"; then
   exit 0
fi
exit 1

/* src.f */
+incdir+src
src/tlx_rsp_pkg.sv
src/rsp_fifo.sv
src/rsp_credit_ctrl.sv
src/rsp_router.sv
src/rdata_splitter.sv
src/tlx_rsp_converter.sv
test/tb_tlx_rsp_converter.sv

/* src/rdata_splitter.sv */
/* asks the TLX for read data and steers each 64 byte beat into the even or odd lane
   dp/dl records queued per read response decide the lane of each beat */
`timescale 1ns/1ps
`include "tlx_rsp_cfg.svh"

module rdata_splitter (
   input  logic                   clk_tlx,
   input  logic                   rst_n,
   input  logic                   resp_valid,
   input  logic [7:0]             resp_opcode,
   input  logic [1:0]             resp_dl,
   input  logic [1:0]             resp_dp,
   input  logic [`TLX_TAG_W-1:0]  resp_afutag,
   input  logic                   resp_data_valid,
   input  logic [`TLX_DATA_W-1:0] resp_data_bus,
   input  logic                   resp_data_bdi,
   output logic                   resp_rd_req,
   output logic [2:0]             resp_rd_cnt,
   output logic                   rdata_e_valid,
   output logic                   rdata_e_bdi,
   output logic [`TLX_DATA_W-1:0] rdata_e,
   output logic                   rdata_o_valid,
   output logic                   rdata_o_bdi,
   output logic [`TLX_DATA_W-1:0] rdata_o,
   output tlx_rsp_pkg::cnt_t      lane_count,
   output logic                   dpdl_miss,
   // dp/dl odd, dp/dl even, lane odd, lane even
   output logic [3:0]             ovfl
);
   import tlx_rsp_pkg::*;

   logic       is_rd;
   logic       is_128b;
   logic       wr_tgl;
   logic       rd_tgl;
   logic [1:0] pos_64b;
   dpdl_t      dpdl_e_din;
   dpdl_t      dpdl_o_din;
   dpdl_t      dpdl_e_dout;
   dpdl_t      dpdl_o_dout;
   dpdl_t      dpdl_sel;
   logic       dpdl_e_valid;
   logic       dpdl_o_valid;
   logic       dpdl_hit;
   logic       beat_q;
   lane_t      beat_din_q;
   lane_t      lane_din_q;
   lane_t      lane_e_dout;
   lane_t      lane_o_dout;
   logic       lane_e_wr;
   logic       lane_o_wr;
   logic       lane_e_empty;
   logic       lane_o_empty;

   // ------------------------------
   // write side, one record per expected beat
   assign is_rd   = resp_valid && (resp_opcode == `OPC_READ_RESP);
   assign is_128b = (resp_dl == 2'd2);

   // 64B position from tag bits 8:7, falls back to resp_dp
   assign pos_64b = (resp_afutag[8:7] == 2'b01) ? 2'd0 :
                    (resp_afutag[8:7] == 2'b10) ? 2'd1 : resp_dp;

   // the write toggle picks which fifo the first 128B beat pops from,
   // so each fifo keeps its own lane and that beat follows the toggle
   assign dpdl_e_din = {is_128b ? 2'd0 : pos_64b, resp_dl};
   assign dpdl_o_din = {is_128b ? 2'd1 : pos_64b, resp_dl};

   // 64B responses alternate fifos, starting with even
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_tgl      <= 1'b0;
         rd_tgl      <= 1'b0;
         resp_rd_req <= 1'b0;
      end
      else
      begin
         if (is_rd && (resp_dl == 2'd1))
            wr_tgl <= !wr_tgl;
         // beats pop even and odd fifo in turn
         if (resp_data_valid)
            rd_tgl <= !rd_tgl;
         resp_rd_req <= is_rd;
      end
   end

   rsp_fifo #(.T(dpdl_t), .AW(`DPDL_FIFO_AW)) u_dpdl_e (
      .clk_tlx (clk_tlx),
      .rst_n   (rst_n),
      .wr_en   (is_rd && (is_128b || ((resp_dl == 2'd1) && !wr_tgl))),
      .din     (dpdl_e_din),
      .rd_en   (resp_data_valid && !rd_tgl),
      .dout    (dpdl_e_dout),
      .valid   (dpdl_e_valid),
      .count   (),
      .empty   (),
      .overflow(ovfl[2])
   );

   rsp_fifo #(.T(dpdl_t), .AW(`DPDL_FIFO_AW)) u_dpdl_o (
      .clk_tlx (clk_tlx),
      .rst_n   (rst_n),
      .wr_en   (is_rd && (is_128b || ((resp_dl == 2'd1) && wr_tgl))),
      .din     (dpdl_o_din),
      .rd_en   (resp_data_valid && rd_tgl),
      .dout    (dpdl_o_dout),
      .valid   (dpdl_o_valid),
      .count   (),
      .empty   (),
      .overflow(ovfl[3])
   );

   // ------------------------------
   // read side, beat lines up with its popped record
   assign dpdl_sel  = dpdl_e_valid ? dpdl_e_dout : dpdl_o_dout;
   assign dpdl_hit  = dpdl_e_valid || dpdl_o_valid;
   assign dpdl_miss = beat_q && !dpdl_hit;

   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         beat_q    <= 1'b0;
         lane_e_wr <= 1'b0;
         lane_o_wr <= 1'b0;
      end
      else
      begin
         beat_q    <= resp_data_valid;
         lane_e_wr <= beat_q && dpdl_hit && (dpdl_sel.dp == 2'd0);
         lane_o_wr <= beat_q && dpdl_hit && (dpdl_sel.dp == 2'd1);
      end
   end

   // payload pipe, one shared register feeds both lanes
   always_ff @(posedge clk_tlx)
   begin
      resp_rd_cnt <= {1'b0, resp_dl};
      beat_din_q  <= {resp_data_bdi, resp_data_bus};
      lane_din_q  <= beat_din_q;
   end

   // ------------------------------
   // lane fifos
   rsp_fifo #(.T(lane_t), .AW(`DATA_FIFO_AW)) u_lane_e (
      .clk_tlx (clk_tlx),
      .rst_n   (rst_n),
      .wr_en   (lane_e_wr),
      .din     (lane_din_q),
      .rd_en   (!lane_e_empty),
      .dout    (lane_e_dout),
      .valid   (rdata_e_valid),
      .count   (lane_count),
      .empty   (lane_e_empty),
      .overflow(ovfl[0])
   );

   rsp_fifo #(.T(lane_t), .AW(`DATA_FIFO_AW)) u_lane_o (
      .clk_tlx (clk_tlx),
      .rst_n   (rst_n),
      .wr_en   (lane_o_wr),
      .din     (lane_din_q),
      .rd_en   (!lane_o_empty),
      .dout    (lane_o_dout),
      .valid   (rdata_o_valid),
      .count   (),
      .empty   (lane_o_empty),
      .overflow(ovfl[1])
   );

   assign rdata_e_bdi = lane_e_dout.bdi;
   assign rdata_e     = lane_e_dout.data;
   assign rdata_o_bdi = lane_o_dout.bdi;
   assign rdata_o     = lane_o_dout.data;

endmodule

/* src/rsp_credit_ctrl.sv */
/* returns one response credit to the TLX for each response taken
   credit is held back while the info FIFOs or the even lane FIFO fill up */
`timescale 1ns/1ps
`include "tlx_rsp_cfg.svh"

module rsp_credit_ctrl (
   input  logic               clk_tlx,
   input  logic               rst_n,
   input  logic               resp_valid,
   input  tlx_rsp_pkg::cnt_t  rd_info_count,
   input  tlx_rsp_pkg::cnt_t  wr_info_count,
   input  tlx_rsp_pkg::cnt_t  lane_count,
   output logic               resp_credit
);
   import tlx_rsp_pkg::*;

   // info fifos count as filling from half depth on
   localparam cnt_t INFO_HALF = cnt_t'(2 ** (`INFO_FIFO_AW - 1));
   localparam cnt_t LANE_HOLD = cnt_t'(`DATA_FIFO_HOLD);

   cnt_t unret;
   logic hold;

   assign hold = (rd_info_count >= INFO_HALF) || (wr_info_count >= INFO_HALF)
               || (lane_count > LANE_HOLD);

   // ------------------------------
   // responses taken but not yet paid back
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
         unret <= '0;
      else if (resp_valid && !resp_credit)
         unret <= unret + 1'b1;
      else if (!resp_valid && resp_credit)
         unret <= unret - 1'b1;
   end

   // ------------------------------
   // credit pulse
   // with only one left, skip the cycle after a pulse so the last one is not paid twice
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
         resp_credit <= 1'b0;
      else if (hold)
         resp_credit <= 1'b0;
      else
         resp_credit <= (unret > cnt_t'(1)) || ((unret == cnt_t'(1)) && !resp_credit);
   end

endmodule

/* src/rsp_fifo.sv */
/* single clock FIFO with a registered read port
   payload type and depth are set per instance, a write into a full FIFO is dropped */
`timescale 1ns/1ps

module rsp_fifo #(
   parameter type T  = logic [31:0],
   parameter int  AW = 5
) (
   input  logic               clk_tlx,
   input  logic               rst_n,
   input  logic               wr_en,
   input  T                   din,
   input  logic               rd_en,
   output T                   dout,
   output logic               valid,
   output tlx_rsp_pkg::cnt_t  count,
   output logic               empty,
   output logic               overflow
);
   import tlx_rsp_pkg::*;

   localparam logic [AW:0] FULL = {1'b1, {AW{1'b0}}};

   T              mem [2**AW];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   fill;
   logic          do_wr;
   logic          do_rd;

   // a read of an empty buffer is ignored, a write into a full one is lost
   assign do_wr    = wr_en && (fill != FULL);
   assign do_rd    = rd_en && (fill != '0);
   assign empty    = (fill == '0);
   assign overflow = wr_en && !do_wr;
   assign count    = cnt_t'(fill);

   // storage and read data
   always_ff @(posedge clk_tlx)
   begin
      if (do_wr)
         mem[wr_ptr] <= din;
      if (do_rd)
         dout <= mem[rd_ptr];
   end

   // pointers and fill level
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
         valid  <= 1'b0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         // both at once leaves the level alone
         if (do_wr && !do_rd)
            fill <= fill + 1'b1;
         else if (do_rd && !do_wr)
            fill <= fill - 1'b1;
         // dout is good the cycle after the read
         valid <= do_rd;
      end
   end

endmodule

/* src/rsp_router.sv */
/* sorts TLX responses by tag into the write and read info FIFOs
   the read FIFO output is split again into read and interrupt channels */
`timescale 1ns/1ps
`include "tlx_rsp_cfg.svh"

module rsp_router (
   input  logic                  clk_tlx,
   input  logic                  rst_n,
   // response from the TLX
   input  logic                  resp_valid,
   input  logic [`TLX_TAG_W-1:0] resp_afutag,
   input  logic [7:0]            resp_opcode,
   input  logic [3:0]            resp_code,
   input  logic [1:0]            resp_dl,
   input  logic [1:0]            resp_dp,
   // write channel
   output logic                  w_rsp_valid,
   output logic [`TLX_TAG_W-1:0] w_rsp_afutag,
   output logic [7:0]            w_rsp_opcode,
   output logic [3:0]            w_rsp_code,
   output logic [1:0]            w_rsp_dl,
   output logic [1:0]            w_rsp_dp,
   // read channel
   output logic                  r_rsp_valid,
   output logic [`TLX_TAG_W-1:0] r_rsp_afutag,
   output logic [7:0]            r_rsp_opcode,
   output logic [3:0]            r_rsp_code,
   output logic [1:0]            r_rsp_dl,
   output logic [1:0]            r_rsp_dp,
   // interrupt channel
   output logic                  i_rsp_valid,
   output logic [`TLX_TAG_W-1:0] i_rsp_afutag,
   output logic [7:0]            i_rsp_opcode,
   output logic [3:0]            i_rsp_code,
   // fill levels and faults
   output tlx_rsp_pkg::cnt_t     rd_info_count,
   output tlx_rsp_pkg::cnt_t     wr_info_count,
   output logic                  rd_info_ovfl,
   output logic                  wr_info_ovfl
);
   import tlx_rsp_pkg::*;

   rsp_info_t info_q;
   rsp_info_t rd_dout;
   rsp_info_t wr_dout;
   logic      rd_wr_en;
   logic      wr_wr_en;
   logic      rd_empty;
   logic      wr_empty;
   logic      rd_valid;
   logic      wr_valid;
   logic      is_intr;

   // ------------------------------
   // input stage
   // tag bit 15 marks a read or interrupt response
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rd_wr_en <= 1'b0;
         wr_wr_en <= 1'b0;
      end
      else
      begin
         rd_wr_en <= resp_valid && resp_afutag[15];
         wr_wr_en <= resp_valid && !resp_afutag[15];
      end
   end

   // one record serves both fifos, only one of them writes it
   always_ff @(posedge clk_tlx)
   begin
      info_q <= {resp_dp, resp_dl, resp_code, resp_opcode, resp_afutag};
   end

   // ------------------------------
   // info fifos, drained whenever they hold something
   rsp_fifo #(.T(rsp_info_t), .AW(`INFO_FIFO_AW)) u_rd_info (
      .clk_tlx (clk_tlx),
      .rst_n   (rst_n),
      .wr_en   (rd_wr_en),
      .din     (info_q),
      .rd_en   (!rd_empty),
      .dout    (rd_dout),
      .valid   (rd_valid),
      .count   (rd_info_count),
      .empty   (rd_empty),
      .overflow(rd_info_ovfl)
   );

   rsp_fifo #(.T(rsp_info_t), .AW(`INFO_FIFO_AW)) u_wr_info (
      .clk_tlx (clk_tlx),
      .rst_n   (rst_n),
      .wr_en   (wr_wr_en),
      .din     (info_q),
      .rd_en   (!wr_empty),
      .dout    (wr_dout),
      .valid   (wr_valid),
      .count   (wr_info_count),
      .empty   (wr_empty),
      .overflow(wr_info_ovfl)
   );

   // ------------------------------
   // output channels
   assign w_rsp_valid  = wr_valid;
   assign w_rsp_afutag = wr_dout.tag;
   assign w_rsp_opcode = wr_dout.opcode;
   assign w_rsp_code   = wr_dout.code;
   assign w_rsp_dl     = wr_dout.dl;
   assign w_rsp_dp     = wr_dout.dp;

   // the interrupt tag shares the read fifo
   assign is_intr      = (rd_dout.tag == `INTR_TAG);
   assign r_rsp_valid  = rd_valid && !is_intr;
   assign r_rsp_afutag = rd_dout.tag;
   assign r_rsp_opcode = rd_dout.opcode;
   assign r_rsp_code   = rd_dout.code;
   assign r_rsp_dl     = rd_dout.dl;
   assign r_rsp_dp     = rd_dout.dp;

   assign i_rsp_valid  = rd_valid && is_intr;
   assign i_rsp_afutag = rd_dout.tag;
   assign i_rsp_opcode = rd_dout.opcode;
   assign i_rsp_code   = rd_dout.code;

endmodule

/* src/tlx_rsp_cfg.svh */
/* widths, depths and fixed codes of the TLX response converter
   included by the package and by every RTL block that needs a constant */
`ifndef TLX_RSP_CFG_SVH
`define TLX_RSP_CFG_SVH

// ------------------------------
// bus widths
`define TLX_DATA_W        512
`define TLX_TAG_W         16

// fifo address widths, depth is 2**aw
`define INFO_FIFO_AW      5
`define DPDL_FIFO_AW      5
`define DATA_FIFO_AW      4

// ------------------------------
// response codes
`define OPC_READ_RESP     8'h04
// interrupt responses come back on this tag
`define INTR_TAG          16'hC000

// ------------------------------
// credit handling
`define RSP_INIT_CREDIT   7
// lane fifo level above which credit is held back
`define DATA_FIFO_HOLD    5

`endif

/* src/tlx_rsp_converter.sv */
/* TLX response converter top, splits responses into write, read and interrupt
   channels plus even and odd read data lanes, and returns response credit */
`timescale 1ns/1ps
`include "tlx_rsp_cfg.svh"

module tlx_rsp_converter (
   input  logic                   clk_tlx,
   input  logic                   rst_n,
   // TLX response
   input  logic                   resp_valid,
   input  logic [`TLX_TAG_W-1:0]  resp_afutag,
   input  logic [7:0]             resp_opcode,
   input  logic [3:0]             resp_code,
   input  logic [1:0]             resp_dl,
   input  logic [1:0]             resp_dp,
   // TLX read data
   output logic                   resp_rd_req,
   output logic [2:0]             resp_rd_cnt,
   input  logic                   resp_data_valid,
   input  logic [`TLX_DATA_W-1:0] resp_data_bus,
   input  logic                   resp_data_bdi,
   // TLX credit
   output logic                   resp_credit,
   output logic [6:0]             resp_initial_credit,
   // write channel
   output logic                   w_rsp_valid,
   output logic [`TLX_TAG_W-1:0]  w_rsp_afutag,
   output logic [7:0]             w_rsp_opcode,
   output logic [3:0]             w_rsp_code,
   output logic [1:0]             w_rsp_dl,
   output logic [1:0]             w_rsp_dp,
   // read channel and lanes
   output logic                   r_rsp_valid,
   output logic [`TLX_TAG_W-1:0]  r_rsp_afutag,
   output logic [7:0]             r_rsp_opcode,
   output logic [3:0]             r_rsp_code,
   output logic [1:0]             r_rsp_dl,
   output logic [1:0]             r_rsp_dp,
   output logic                   rdata_e_valid,
   output logic                   rdata_e_bdi,
   output logic [`TLX_DATA_W-1:0] rdata_e,
   output logic                   rdata_o_valid,
   output logic                   rdata_o_bdi,
   output logic [`TLX_DATA_W-1:0] rdata_o,
   // interrupt channel
   output logic                   i_rsp_valid,
   output logic [`TLX_TAG_W-1:0]  i_rsp_afutag,
   output logic [7:0]             i_rsp_opcode,
   output logic [3:0]             i_rsp_code,
   // fault flags
   output logic [5:0]             fir_fifo_overflow,
   output logic                   fir_rsp_err
);
   import tlx_rsp_pkg::*;

   cnt_t       rd_info_count;
   cnt_t       wr_info_count;
   cnt_t       lane_count;
   logic       rd_info_ovfl;
   logic       wr_info_ovfl;
   logic [3:0] split_ovfl;
   logic       dpdl_miss;

   assign resp_initial_credit = 7'(`RSP_INIT_CREDIT);

   rsp_credit_ctrl u_credit (
      .clk_tlx      (clk_tlx),
      .rst_n        (rst_n),
      .resp_valid   (resp_valid),
      .rd_info_count(rd_info_count),
      .wr_info_count(wr_info_count),
      .lane_count   (lane_count),
      .resp_credit  (resp_credit)
   );

   rsp_router u_router (
      .clk_tlx      (clk_tlx),
      .rst_n        (rst_n),
      .resp_valid   (resp_valid),
      .resp_afutag  (resp_afutag),
      .resp_opcode  (resp_opcode),
      .resp_code    (resp_code),
      .resp_dl      (resp_dl),
      .resp_dp      (resp_dp),
      .w_rsp_valid  (w_rsp_valid),
      .w_rsp_afutag (w_rsp_afutag),
      .w_rsp_opcode (w_rsp_opcode),
      .w_rsp_code   (w_rsp_code),
      .w_rsp_dl     (w_rsp_dl),
      .w_rsp_dp     (w_rsp_dp),
      .r_rsp_valid  (r_rsp_valid),
      .r_rsp_afutag (r_rsp_afutag),
      .r_rsp_opcode (r_rsp_opcode),
      .r_rsp_code   (r_rsp_code),
      .r_rsp_dl     (r_rsp_dl),
      .r_rsp_dp     (r_rsp_dp),
      .i_rsp_valid  (i_rsp_valid),
      .i_rsp_afutag (i_rsp_afutag),
      .i_rsp_opcode (i_rsp_opcode),
      .i_rsp_code   (i_rsp_code),
      .rd_info_count(rd_info_count),
      .wr_info_count(wr_info_count),
      .rd_info_ovfl (rd_info_ovfl),
      .wr_info_ovfl (wr_info_ovfl)
   );

   rdata_splitter u_splitter (
      .clk_tlx        (clk_tlx),
      .rst_n          (rst_n),
      .resp_valid     (resp_valid),
      .resp_opcode    (resp_opcode),
      .resp_dl        (resp_dl),
      .resp_dp        (resp_dp),
      .resp_afutag    (resp_afutag),
      .resp_data_valid(resp_data_valid),
      .resp_data_bus  (resp_data_bus),
      .resp_data_bdi  (resp_data_bdi),
      .resp_rd_req    (resp_rd_req),
      .resp_rd_cnt    (resp_rd_cnt),
      .rdata_e_valid  (rdata_e_valid),
      .rdata_e_bdi    (rdata_e_bdi),
      .rdata_e        (rdata_e),
      .rdata_o_valid  (rdata_o_valid),
      .rdata_o_bdi    (rdata_o_bdi),
      .rdata_o        (rdata_o),
      .lane_count     (lane_count),
      .dpdl_miss      (dpdl_miss),
      .ovfl           (split_ovfl)
   );

   // ------------------------------
   // sticky faults, cleared only by reset
   // a beat with no dp/dl record means a response went missing or came late
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         fir_fifo_overflow <= '0;
         fir_rsp_err       <= 1'b0;
      end
      else
      begin
         fir_fifo_overflow <= fir_fifo_overflow | {rd_info_ovfl, wr_info_ovfl, split_ovfl};
         fir_rsp_err       <= fir_rsp_err | dpdl_miss;
      end
   end

endmodule

/* src/tlx_rsp_pkg.sv */
/* record types shared by the TLX response converter blocks
   import into a module body, use scoped names in port lists */
`include "tlx_rsp_cfg.svh"

package tlx_rsp_pkg;

   // ------------------------------
   // fifo fill level
   // wide enough for any depth used in this design
   typedef logic [7:0] cnt_t;

   // ------------------------------
   // one response as stored in an info fifo
   // dp sits on top, tag at the bottom, 32 bits in all
   typedef struct packed {
      logic [1:0]             dp;
      logic [1:0]             dl;
      logic [3:0]             code;
      logic [7:0]             opcode;
      logic [`TLX_TAG_W-1:0]  tag;
   } rsp_info_t;

   // ------------------------------
   // bookkeeping for one expected data beat
   // dp picks the lane, dl is the response length
   typedef struct packed {
      logic [1:0] dp;
      logic [1:0] dl;
   } dpdl_t;

   // ------------------------------
   // one 64 byte beat on its way through a lane fifo
   typedef struct packed {
      logic                   bdi;
      logic [`TLX_DATA_W-1:0] data;
   } lane_t;

endpackage

/* test/rsp_tests.dat */
// kind test then five fields then exp, kind 0 response: tag opcode code dl dp, exp 0 wr 1 rd 2 intr
// kind 1 beat: word bdi 0 0 0, exp 0 even lane 1 odd lane 3 no lane
0 01 1234 08 0 1 0 0
0 01 0042 08 3 2 1 0
0 02 C000 0C 0 0 0 2
0 03 8080 04 0 1 0 1
1 03 A5A50003 1 0 0 0 0
0 04 8100 04 2 1 0 1
1 04 5A5A0004 0 0 0 0 1
0 05 8000 04 0 1 1 1
0 05 8180 04 0 1 0 1
1 05 11110005 0 0 0 0 1
1 05 22220005 1 0 0 0 0
0 06 8200 04 0 2 0 1
1 06 33330006 0 0 0 0 0
1 06 44440006 1 0 0 0 1
0 07 8080 04 0 1 0 1
0 07 8300 04 0 2 0 1
1 07 55550007 0 0 0 0 0
1 07 66660007 1 0 0 0 1
1 07 77770007 0 0 0 0 0
0 08 0777 08 5 0 0 0
0 08 C000 0C 9 0 0 2
0 08 8480 04 1 1 2 1
1 08 88880008 1 0 0 0 0
1 09 DEAD0009 0 0 0 0 3

/* test/tb_tlx_rsp_converter.sv */
/* testbench for the TLX response converter, reads test/rsp_tests.dat from the project root
   drives responses and data beats, then checks every output channel in order per test */
`timescale 1ns/1ps
`include "tlx_rsp_cfg.svh"

module tb_tlx_rsp_converter;

   localparam int MAX_LINES = 64;
   localparam int LINE_W    = 8;

   // ------------------------------
   // DUT signals
   logic                   clk_tlx;
   logic                   rst_n;
   logic                   resp_valid;
   logic [`TLX_TAG_W-1:0]  resp_afutag;
   logic [7:0]             resp_opcode;
   logic [3:0]             resp_code;
   logic [1:0]             resp_dl;
   logic [1:0]             resp_dp;
   logic                   resp_rd_req;
   logic [2:0]             resp_rd_cnt;
   logic                   resp_data_valid;
   logic [`TLX_DATA_W-1:0] resp_data_bus;
   logic                   resp_data_bdi;
   logic                   resp_credit;
   logic [6:0]             resp_initial_credit;
   logic                   w_rsp_valid;
   logic [`TLX_TAG_W-1:0]  w_rsp_afutag;
   logic [7:0]             w_rsp_opcode;
   logic [3:0]             w_rsp_code;
   logic [1:0]             w_rsp_dl;
   logic [1:0]             w_rsp_dp;
   logic                   r_rsp_valid;
   logic [`TLX_TAG_W-1:0]  r_rsp_afutag;
   logic [7:0]             r_rsp_opcode;
   logic [3:0]             r_rsp_code;
   logic [1:0]             r_rsp_dl;
   logic [1:0]             r_rsp_dp;
   logic                   rdata_e_valid;
   logic                   rdata_e_bdi;
   logic [`TLX_DATA_W-1:0] rdata_e;
   logic                   rdata_o_valid;
   logic                   rdata_o_bdi;
   logic [`TLX_DATA_W-1:0] rdata_o;
   logic                   i_rsp_valid;
   logic [`TLX_TAG_W-1:0]  i_rsp_afutag;
   logic [7:0]             i_rsp_opcode;
   logic [3:0]             i_rsp_code;
   logic [5:0]             fir_fifo_overflow;
   logic                   fir_rsp_err;

   // ------------------------------
   // test vectors, eight words per file line
   logic [31:0] tv [0:MAX_LINES*LINE_W-1];
   int          n_lines;
   int          cycle_cnt   = 0;
   int          cycle_limit = 1000;
   int          err_count   = 0;
   int          resp_sent   = 0;
   int          credit_cnt  = 0;
   logic        err_expected = 1'b0;
   logic        ovfl_reported = 1'b0;

   // records are {dp, dl, code, opcode, tag}, lanes are {bdi, data}
   logic [31:0]  exp_w[$];
   logic [31:0]  act_w[$];
   logic [31:0]  exp_r[$];
   logic [31:0]  act_r[$];
   logic [31:0]  exp_i[$];
   logic [31:0]  act_i[$];
   logic [2:0]   exp_req[$];
   logic [2:0]   act_req[$];
   logic [512:0] exp_e[$];
   logic [512:0] act_e[$];
   logic [512:0] exp_o[$];
   logic [512:0] act_o[$];

   tlx_rsp_converter u_tlx_rsp_converter (.*);

   initial
   begin
      clk_tlx = 1'b0;
      forever #20 clk_tlx = ~clk_tlx;
   end

   // ------------------------------
   // watchdog, limit set from the number of file lines
   always @(posedge clk_tlx)
   begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit)
      begin
         $display("timeout after %0d cycles, the DUT stopped producing outputs", cycle_cnt);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // monitor samples mid cycle, outputs are all registered
   always @(negedge clk_tlx)
   begin
      if (w_rsp_valid)
         act_w.push_back({w_rsp_dp, w_rsp_dl, w_rsp_code, w_rsp_opcode, w_rsp_afutag});
      if (r_rsp_valid)
         act_r.push_back({r_rsp_dp, r_rsp_dl, r_rsp_code, r_rsp_opcode, r_rsp_afutag});
      if (i_rsp_valid)
         act_i.push_back({4'b0, i_rsp_code, i_rsp_opcode, i_rsp_afutag});
      if (resp_rd_req)
         act_req.push_back(resp_rd_cnt);
      if (rdata_e_valid)
         act_e.push_back({rdata_e_bdi, rdata_e});
      if (rdata_o_valid)
         act_o.push_back({rdata_o_bdi, rdata_o});
      if (resp_credit)
         credit_cnt++;
      // overflow must never show up
      if (rst_n && (fir_fifo_overflow != 6'd0) && !ovfl_reported)
      begin
         ovfl_reported = 1'b1;
         err_count++;
         $display("error at %0t: fir_fifo_overflow went to %b", $time, fir_fifo_overflow);
      end
   end

   // ------------------------------
   // helpers
   task automatic idle_inputs();
      resp_valid      = 1'b0;
      resp_afutag     = '0;
      resp_opcode     = '0;
      resp_code       = '0;
      resp_dl         = '0;
      resp_dp         = '0;
      resp_data_valid = 1'b0;
      resp_data_bus   = '0;
      resp_data_bdi   = 1'b0;
   endtask

   task automatic value_error(input string what, input logic [31:0] e, input logic [31:0] a);
      err_count++;
      $display("error at %0t: %s expected %h got %h", $time, what, e, a);
   endtask

   task automatic lane_error(input string what, input logic [512:0] e, input logic [512:0] a);
      err_count++;
      $display("error at %0t: %s expected bdi %b word %h got bdi %b word %h", $time, what,
               e[512], e[31:0], a[512], a[31:0]);
   endtask

   task automatic leftover_check(input string what, input int n_exp, input int n_act);
      if ((n_exp != 0) || (n_act != 0))
      begin
         err_count++;
         $display("error at %0t: %s is missing %0d items and has %0d extra", $time, what,
                  n_exp, n_act);
      end
   endtask

   function automatic logic outputs_done();
      return (act_w.size() >= exp_w.size()) && (act_r.size() >= exp_r.size())
          && (act_i.size() >= exp_i.size()) && (act_req.size() >= exp_req.size())
          && (act_e.size() >= exp_e.size()) && (act_o.size() >= exp_o.size())
          && (credit_cnt >= resp_sent);
   endfunction

   // one file line on one cycle, expected items queued as it goes out
   task automatic drive_line(input int ln);
      int          base;
      logic [31:0] ch;
      logic [31:0] word;
      base = ln * LINE_W;
      ch   = tv[base+7];
      word = tv[base+2];
      @(negedge clk_tlx);
      idle_inputs();
      if (tv[base] == 32'd0)
      begin
         resp_valid  = 1'b1;
         resp_afutag = tv[base+2][15:0];
         resp_opcode = tv[base+3][7:0];
         resp_code   = tv[base+4][3:0];
         resp_dl     = tv[base+5][1:0];
         resp_dp     = tv[base+6][1:0];
         resp_sent++;
         // a read response asks for its data, count is its dl
         if (resp_opcode == `OPC_READ_RESP)
            exp_req.push_back({1'b0, resp_dl});
         if (ch == 32'd0)
            exp_w.push_back({resp_dp, resp_dl, resp_code, resp_opcode, resp_afutag});
         else if (ch == 32'd1)
            exp_r.push_back({resp_dp, resp_dl, resp_code, resp_opcode, resp_afutag});
         else if (ch == 32'd2)
            exp_i.push_back({4'b0, resp_code, resp_opcode, resp_afutag});
         else
         begin
            err_count++;
            $display("test file line %0d has an unknown channel code %0d", ln + 1, ch);
         end
      end
      else
      begin
         resp_data_valid = 1'b1;
         resp_data_bus   = {(`TLX_DATA_W/32){word}};
         resp_data_bdi   = tv[base+3][0];
         if (ch == 32'd0)
            exp_e.push_back({resp_data_bdi, resp_data_bus});
         else if (ch == 32'd1)
            exp_o.push_back({resp_data_bdi, resp_data_bus});
         else
            err_expected = 1'b1;
      end
   endtask

   // compare everything in order, then drop leftovers so the next test starts clean
   task automatic check_channels();
      logic [31:0]  a32;
      logic [31:0]  e32;
      logic [512:0] a_ln;
      logic [512:0] e_ln;
      while ((exp_w.size() > 0) && (act_w.size() > 0))
      begin
         e32 = exp_w.pop_front();
         a32 = act_w.pop_front();
         if (a32 != e32)
            value_error("write channel", e32, a32);
      end
      while ((exp_r.size() > 0) && (act_r.size() > 0))
      begin
         e32 = exp_r.pop_front();
         a32 = act_r.pop_front();
         if (a32 != e32)
            value_error("read channel", e32, a32);
      end
      while ((exp_i.size() > 0) && (act_i.size() > 0))
      begin
         e32 = exp_i.pop_front();
         a32 = act_i.pop_front();
         if (a32 != e32)
            value_error("interrupt channel", e32, a32);
      end
      while ((exp_req.size() > 0) && (act_req.size() > 0))
      begin
         e32 = {29'd0, exp_req.pop_front()};
         a32 = {29'd0, act_req.pop_front()};
         if (a32 != e32)
            value_error("resp_rd_cnt", e32, a32);
      end
      while ((exp_e.size() > 0) && (act_e.size() > 0))
      begin
         e_ln = exp_e.pop_front();
         a_ln = act_e.pop_front();
         if (a_ln != e_ln)
            lane_error("even lane", e_ln, a_ln);
      end
      while ((exp_o.size() > 0) && (act_o.size() > 0))
      begin
         e_ln = exp_o.pop_front();
         a_ln = act_o.pop_front();
         if (a_ln != e_ln)
            lane_error("odd lane", e_ln, a_ln);
      end
      leftover_check("write channel", exp_w.size(), act_w.size());
      leftover_check("read channel", exp_r.size(), act_r.size());
      leftover_check("interrupt channel", exp_i.size(), act_i.size());
      leftover_check("read request", exp_req.size(), act_req.size());
      leftover_check("even lane", exp_e.size(), act_e.size());
      leftover_check("odd lane", exp_o.size(), act_o.size());
      exp_w.delete();
      act_w.delete();
      exp_r.delete();
      act_r.delete();
      exp_i.delete();
      act_i.delete();
      exp_req.delete();
      act_req.delete();
      exp_e.delete();
      act_e.delete();
      exp_o.delete();
      act_o.delete();
      // every response taken is paid back once
      if (credit_cnt != resp_sent)
         value_error("credit pulse count", resp_sent, credit_cnt);
   endtask

   // ------------------------------
   // main sequence
   initial
   begin
      int i;
      int ln;
      int cur_test;
      int err_before;
      int tests_run;
      int tests_passed;
      tests_run    = 0;
      tests_passed = 0;
      idle_inputs();
      rst_n = 1'b0;
      for (i = 0; i < MAX_LINES * LINE_W; i++)
         tv[i] = '1;
      $readmemh("test/rsp_tests.dat", tv);
      n_lines = 0;
      while ((n_lines < MAX_LINES) && (tv[n_lines*LINE_W] != 32'hFFFF_FFFF))
         n_lines++;
      if (n_lines == 0)
      begin
         err_count++;
         $display("no test lines found in test/rsp_tests.dat");
      end
      cycle_limit = 200 * n_lines + 20;

      repeat (2) @(posedge clk_tlx);
      @(negedge clk_tlx);
      rst_n = 1'b1;
      @(posedge clk_tlx);
      // the TLX starts out with seven response credits
      if (resp_initial_credit != 7'd7)
         value_error("resp_initial_credit", 32'd7, {25'd0, resp_initial_credit});

      ln = 0;
      while (ln < n_lines)
      begin
         cur_test   = tv[ln*LINE_W+1];
         err_before = err_count;
         while ((ln < n_lines) && (tv[ln*LINE_W+1] == cur_test))
         begin
            drive_line(ln);
            ln++;
         end
         @(negedge clk_tlx);
         idle_inputs();
         while (!outputs_done())
            @(posedge clk_tlx);
         // settle so late or extra items get caught
         repeat (8) @(posedge clk_tlx);
         check_channels();
         if (fir_rsp_err !== err_expected)
            value_error("fir_rsp_err", {31'd0, err_expected}, {31'd0, fir_rsp_err});
         tests_run++;
         if (err_count == err_before)
         begin
            tests_passed++;
            $display("test %0d finished, ok", cur_test);
         end
         else
            $display("test %0d finished, %0d errors", cur_test, err_count - err_before);
      end

      $display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run, tests_passed,
               tests_run - tests_passed, err_count);
      if (err_count == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule
